// File: compile.f
+incdir+tb
hdl/blake_pkg.sv
hdl/core_pkg.sv
hdl/header_loader.sv
hdl/state_init.sv
hdl/blake_g.sv
hdl/blake_round.sv
hdl/digest_check.sv
hdl/blake_miner_core.sv
tb/tb_blake_miner.sv

// File: hdl/blake_g.sv
/* two-stage pipelined BLAKE-256 G function */
`timescale 1ns/1ns

module blake_g (
   input  logic              clk,
   input  blake_pkg::word_t  a_i,
   input  blake_pkg::word_t  b_i,
   input  blake_pkg::word_t  c_i,
   input  blake_pkg::word_t  d_i,
   input  blake_pkg::word_t  mc0_i,
   input  blake_pkg::word_t  mc1_i,
   output blake_pkg::word_t  a_o,
   output blake_pkg::word_t  b_o,
   output blake_pkg::word_t  c_o,
   output blake_pkg::word_t  d_o
);

   function automatic blake_pkg::word_t ror(input blake_pkg::word_t x, input int unsigned n);
      ror = (x >> n) | (x << (32 - n));
   endfunction

   blake_pkg::word_t a1, b1, c1, d1;
   blake_pkg::word_t a1_q, b1_q, c1_q, d1_q, mc1_q;
   blake_pkg::word_t a2, b2, c2, d2;

   // first half
   assign a1 = a_i + b_i + mc0_i;
   assign d1 = ror(d_i ^ a1, blake_pkg::ROT_A);
   assign c1 = c_i + d1;
   assign b1 = ror(b_i ^ c1, blake_pkg::ROT_B);

   // mc1 rides along so stage 2 sees the word of the same item
   always_ff @(posedge clk) begin
      a1_q  <= a1;
      b1_q  <= b1;
      c1_q  <= c1;
      d1_q  <= d1;
      mc1_q <= mc1_i;
   end

   // second half
   assign a2 = a1_q + b1_q + mc1_q;
   assign d2 = ror(d1_q ^ a2, blake_pkg::ROT_C);
   assign c2 = c1_q + d2;
   assign b2 = ror(b1_q ^ c2, blake_pkg::ROT_D);

   always_ff @(posedge clk) begin
      a_o <= a2;
      b_o <= b2;
      c_o <= c2;
      d_o <= d2;
   end

endmodule

// File: hdl/blake_miner_core.sv
/* BLAKE-256 miner core: header loader, state init, unrolled rounds, digest check */
`timescale 1ns/1ns

module blake_miner_core (
   input  logic              clk,
   input  logic              rst_n_i,
   input  logic              shift_i,
   input  logic              din_i,
   input  core_pkg::nonce_t  nonce_i,
   input  logic              nonce_valid_i,
   input  blake_pkg::word_t  target_i,
   output logic              result_valid_o,
   output logic              match_o,
   output blake_pkg::word_t  hash_o,
   output core_pkg::nonce_t  nonce_o
);

   core_pkg::midstate_t midstate;
   blake_pkg::word_t    msg0, msg1, msg2;

   // stage r feeds round r, the last entry feeds the check
   blake_pkg::state_t               rnd_state [blake_pkg::NUM_ROUNDS+1];
   core_pkg::nonce_t                rnd_nonce [blake_pkg::NUM_ROUNDS+1];
   logic [blake_pkg::NUM_ROUNDS:0]  rnd_valid;

   header_loader i_header_loader (
      .clk        (clk),
      .shift_i    (shift_i),
      .din_i      (din_i),
      .midstate_o (midstate),
      .msg0_o     (msg0),
      .msg1_o     (msg1),
      .msg2_o     (msg2)
   );

   state_init i_state_init (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .nonce_i       (nonce_i),
      .nonce_valid_i (nonce_valid_i),
      .midstate_i    (midstate),
      .state_o       (rnd_state[0]),
      .nonce_o       (rnd_nonce[0]),
      .valid_o       (rnd_valid[0])
   );

   for (genvar r = 0; r < blake_pkg::NUM_ROUNDS; r++) begin : g_round
      blake_round #(
         .ROUND (r)
      ) i_round (
         .clk     (clk),
         .rst_n_i (rst_n_i),
         .state_i (rnd_state[r]),
         .nonce_i (rnd_nonce[r]),
         .valid_i (rnd_valid[r]),
         .msg0_i  (msg0),
         .msg1_i  (msg1),
         .msg2_i  (msg2),
         .state_o (rnd_state[r+1]),
         .nonce_o (rnd_nonce[r+1]),
         .valid_o (rnd_valid[r+1])
      );
   end

   digest_check i_digest_check (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .state_i        (rnd_state[blake_pkg::NUM_ROUNDS]),
      .nonce_i        (rnd_nonce[blake_pkg::NUM_ROUNDS]),
      .valid_i        (rnd_valid[blake_pkg::NUM_ROUNDS]),
      .h7_i           (midstate[7*32 +: 32]),
      .target_i       (target_i),
      .result_valid_o (result_valid_o),
      .match_o        (match_o),
      .hash_o         (hash_o),
      .nonce_o        (nonce_o)
   );

endmodule

// File: hdl/blake_pkg.sv
/* BLAKE-256 word and state types, round constants, message permutations,
   fixed padding of the 80-byte block and the G rotation amounts */
package blake_pkg;

   typedef logic [31:0]  word_t;
   // v0 in the low word, v15 in the high word
   typedef logic [511:0] state_t;

   localparam int NUM_ROUNDS = 8;

   localparam word_t CONST_U [16] = '{
      32'h243F6A88, 32'h85A308D3, 32'h13198A2E, 32'h03707344,
      32'hA4093822, 32'h299F31D0, 32'h082EFA98, 32'hEC4E6C89,
      32'h452821E6, 32'h38D01377, 32'hBE5466CF, 32'h34E90C6C,
      32'hC0AC29B7, 32'hC97C50DD, 32'h3F84D5B5, 32'hB5470917
   };

   localparam logic [3:0] SIGMA [10][16] = '{
      '{ 0,  1,  2,  3,  4,  5,  6,  7,  8,  9, 10, 11, 12, 13, 14, 15},
      '{14, 10,  4,  8,  9, 15, 13,  6,  1, 12,  0,  2, 11,  7,  5,  3},
      '{11,  8, 12,  0,  5,  2, 15, 13, 10, 14,  3,  6,  7,  1,  9,  4},
      '{ 7,  9,  3,  1, 13, 12, 11, 14,  2,  6,  5, 10,  4,  0, 15,  8},
      '{ 9,  0,  5,  7,  2,  4, 10, 15, 14,  1, 11, 12,  6,  8,  3, 13},
      '{ 2, 12,  6, 10,  0, 11,  8,  3,  4, 13,  7,  5, 15, 14,  1,  9},
      '{12,  5,  1, 15, 14, 13,  4, 10,  0,  7,  6,  3,  9,  2,  8, 11},
      '{13, 11,  7, 14, 12,  1,  3,  9,  5,  0, 15,  4,  8,  6,  2, 10},
      '{ 6, 15, 14,  9, 11,  3,  0,  8, 12,  2, 13,  7,  1,  4, 10,  5},
      '{10,  2,  8,  4,  7,  6,  1,  5, 15, 11,  9, 14,  3, 12, 13,  0}
   };

   // bit counter of the final block, 640 bits
   localparam word_t T_COUNT = 32'h00000280;

   // padding words of an 80-byte message, all others zero
   localparam word_t PAD_WORD_4  = 32'h80000000;
   localparam word_t PAD_WORD_13 = 32'h00000001;
   localparam word_t PAD_WORD_15 = 32'h00000280;

   localparam int unsigned ROT_A = 16;
   localparam int unsigned ROT_B = 12;
   localparam int unsigned ROT_C = 8;
   localparam int unsigned ROT_D = 7;

endpackage

// File: hdl/blake_round.sv
/* one BLAKE-256 round, column step then diagonal step,
   with the nonce and valid bit delayed alongside */
`timescale 1ns/1ns

module blake_round #(
   parameter int ROUND = 0
) (
   input  logic               clk,
   input  logic               rst_n_i,
   input  blake_pkg::state_t  state_i,
   input  core_pkg::nonce_t   nonce_i,
   input  logic               valid_i,
   input  blake_pkg::word_t   msg0_i,
   input  blake_pkg::word_t   msg1_i,
   input  blake_pkg::word_t   msg2_i,
   output blake_pkg::state_t  state_o,
   output core_pkg::nonce_t   nonce_o,
   output logic               valid_o
);

   // message block of the final 80-byte chunk, nonce as word 3
   function automatic blake_pkg::word_t msg_word(input logic [3:0] idx,
                                                 input core_pkg::nonce_t nonce,
                                                 input blake_pkg::word_t m0,
                                                 input blake_pkg::word_t m1,
                                                 input blake_pkg::word_t m2);
      case (idx)
         4'd0:    msg_word = m0;
         4'd1:    msg_word = m1;
         4'd2:    msg_word = m2;
         4'd3:    msg_word = nonce;
         4'd4:    msg_word = blake_pkg::PAD_WORD_4;
         4'd13:   msg_word = blake_pkg::PAD_WORD_13;
         4'd15:   msg_word = blake_pkg::PAD_WORD_15;
         default: msg_word = '0;
      endcase
   endfunction

   core_pkg::nonce_t                   nonce_sr [core_pkg::ROUND_LATENCY];
   logic [core_pkg::ROUND_LATENCY-1:0] valid_sr;
   core_pkg::nonce_t                   diag_nonce;
   blake_pkg::state_t                  col_state;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         valid_sr <= '0;
      end else begin
         valid_sr <= {valid_sr[core_pkg::ROUND_LATENCY-2:0], valid_i};
      end
   end

   always_ff @(posedge clk) begin
      nonce_sr[0] <= nonce_i;
      for (int k = 1; k < core_pkg::ROUND_LATENCY; k++) begin
         nonce_sr[k] <= nonce_sr[k-1];
      end
   end

   // tap lines up with the column G outputs
   assign diag_nonce = nonce_sr[core_pkg::G_LATENCY-1];

   for (genvar i = 0; i < 4; i++) begin : g_col
      blake_pkg::word_t mc0, mc1;

      assign mc0 = msg_word(blake_pkg::SIGMA[ROUND][2*i], nonce_i, msg0_i, msg1_i, msg2_i)
                   ^ blake_pkg::CONST_U[blake_pkg::SIGMA[ROUND][2*i+1]];
      assign mc1 = msg_word(blake_pkg::SIGMA[ROUND][2*i+1], nonce_i, msg0_i, msg1_i, msg2_i)
                   ^ blake_pkg::CONST_U[blake_pkg::SIGMA[ROUND][2*i]];

      blake_g i_g (
         .clk   (clk),
         .a_i   (state_i[32*i +: 32]),
         .b_i   (state_i[32*(i+4) +: 32]),
         .c_i   (state_i[32*(i+8) +: 32]),
         .d_i   (state_i[32*(i+12) +: 32]),
         .mc0_i (mc0),
         .mc1_i (mc1),
         .a_o   (col_state[32*i +: 32]),
         .b_o   (col_state[32*(i+4) +: 32]),
         .c_o   (col_state[32*(i+8) +: 32]),
         .d_o   (col_state[32*(i+12) +: 32])
      );
   end

   // diagonal i works on v(i), v(4+(i+1)%4), v(8+(i+2)%4), v(12+(i+3)%4)
   for (genvar i = 0; i < 4; i++) begin : g_diag
      blake_pkg::word_t mc0, mc1;

      assign mc0 = msg_word(blake_pkg::SIGMA[ROUND][2*i+8], diag_nonce, msg0_i, msg1_i, msg2_i)
                   ^ blake_pkg::CONST_U[blake_pkg::SIGMA[ROUND][2*i+9]];
      assign mc1 = msg_word(blake_pkg::SIGMA[ROUND][2*i+9], diag_nonce, msg0_i, msg1_i, msg2_i)
                   ^ blake_pkg::CONST_U[blake_pkg::SIGMA[ROUND][2*i+8]];

      blake_g i_g (
         .clk   (clk),
         .a_i   (col_state[32*i +: 32]),
         .b_i   (col_state[32*(4+(i+1)%4) +: 32]),
         .c_i   (col_state[32*(8+(i+2)%4) +: 32]),
         .d_i   (col_state[32*(12+(i+3)%4) +: 32]),
         .mc0_i (mc0),
         .mc1_i (mc1),
         .a_o   (state_o[32*i +: 32]),
         .b_o   (state_o[32*(4+(i+1)%4) +: 32]),
         .c_o   (state_o[32*(8+(i+2)%4) +: 32]),
         .d_o   (state_o[32*(12+(i+3)%4) +: 32])
      );
   end

   assign nonce_o = nonce_sr[core_pkg::ROUND_LATENCY-1];
   assign valid_o = valid_sr[core_pkg::ROUND_LATENCY-1];

endmodule

// File: hdl/core_pkg.sv
/* miner pipeline types and latencies: nonce, midstate, header length */
package core_pkg;

   typedef logic [31:0] nonce_t;
   typedef logic [8*$bits(blake_pkg::word_t)-1:0] midstate_t;

   // midstate plus message words 0 to 2
   localparam int HEADER_BITS = 352;

   localparam int G_LATENCY     = 2;
   localparam int ROUND_LATENCY = 2 * G_LATENCY;

   // state init, all rounds, digest check
   localparam int CORE_LATENCY = 1 + blake_pkg::NUM_ROUNDS * ROUND_LATENCY + 1;

endpackage

// File: hdl/digest_check.sv
/* digest word 7 finalization and target compare */
`timescale 1ns/1ns

module digest_check (
   input  logic               clk,
   input  logic               rst_n_i,
   input  blake_pkg::state_t  state_i,
   input  core_pkg::nonce_t   nonce_i,
   input  logic               valid_i,
   input  blake_pkg::word_t   h7_i,
   input  blake_pkg::word_t   target_i,
   output logic               result_valid_o,
   output logic               match_o,
   output blake_pkg::word_t   hash_o,
   output core_pkg::nonce_t   nonce_o
);

   blake_pkg::word_t digest7;
   logic             below;

   // h7' = h7 ^ v7 ^ v15, salt is zero
   assign digest7 = h7_i ^ state_i[7*32 +: 32] ^ state_i[15*32 +: 32];
   assign below   = (digest7 <= target_i);

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         result_valid_o <= 1'b0;
         match_o        <= 1'b0;
      end else begin
         result_valid_o <= valid_i;
         match_o        <= valid_i & below;
      end
   end

   always_ff @(posedge clk) begin
      hash_o  <= digest7;
      nonce_o <= nonce_i;
   end

endmodule

// File: hdl/header_loader.sv
/* serial header shift register, parallel midstate and message words 0 to 2 */
`timescale 1ns/1ns

module header_loader (
   input  logic                 clk,
   input  logic                 shift_i,
   input  logic                 din_i,
   output core_pkg::midstate_t  midstate_o,
   output blake_pkg::word_t     msg0_o,
   output blake_pkg::word_t     msg1_o,
   output blake_pkg::word_t     msg2_o
);

   logic [core_pkg::HEADER_BITS-1:0] image;

   // msb first, midstate word 7 enters before everything else
   always_ff @(posedge clk) begin
      if (shift_i) begin
         image <= {image[core_pkg::HEADER_BITS-2:0], din_i};
      end
   end

   assign midstate_o = image[core_pkg::HEADER_BITS-1 -: $bits(core_pkg::midstate_t)];

   // message words sit below the midstate, word 0 shifted in last
   assign msg2_o = image[64 +: 32];
   assign msg1_o = image[32 +: 32];
   assign msg0_o = image[0 +: 32];

endmodule

// File: hdl/state_init.sv
/* nonce capture and initial BLAKE-256 working state */
`timescale 1ns/1ns

module state_init (
   input  logic                 clk,
   input  logic                 rst_n_i,
   input  core_pkg::nonce_t     nonce_i,
   input  logic                 nonce_valid_i,
   input  core_pkg::midstate_t  midstate_i,
   output blake_pkg::state_t    state_o,
   output core_pkg::nonce_t     nonce_o,
   output logic                 valid_o
);

   core_pkg::nonce_t nonce_q;
   logic             valid_q;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= nonce_valid_i;
      end
   end

   always_ff @(posedge clk) begin
      nonce_q <= nonce_i;
   end

   // v0..v7 are the chaining value
   assign state_o[255:0] = midstate_i;

   // v8..v15 from the constants, counter folded into v12 and v13
   assign state_o[8*32 +: 32]  = blake_pkg::CONST_U[0];
   assign state_o[9*32 +: 32]  = blake_pkg::CONST_U[1];
   assign state_o[10*32 +: 32] = blake_pkg::CONST_U[2];
   assign state_o[11*32 +: 32] = blake_pkg::CONST_U[3];
   assign state_o[12*32 +: 32] = blake_pkg::CONST_U[4] ^ blake_pkg::T_COUNT;
   assign state_o[13*32 +: 32] = blake_pkg::CONST_U[5] ^ blake_pkg::T_COUNT;
   assign state_o[14*32 +: 32] = blake_pkg::CONST_U[6];
   assign state_o[15*32 +: 32] = blake_pkg::CONST_U[7];

   assign nonce_o = nonce_q;
   assign valid_o = valid_q;

endmodule

// File: run.sh
#!/bin/sh
# build and run the miner core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
   -f compile.f --top-module tb_blake_miner -Mdir obj_dir -o sim_blake_miner

./obj_dir/sim_blake_miner > sim.log
cat sim.log

if grep -q "Test failed" sim.log; then
   echo "simulation reported a failure, see sim.log"
   exit 1
fi

// File: tb/blake_ref.svh
/* reference model of the 8-round BLAKE-256 compression of the miner block,
   digest word 7 from midstate, message words 0 to 2 and a nonce */
`ifndef BLAKE_REF_SVH
`define BLAKE_REF_SVH

// word indices a, b, c, d of G0..G7, four columns then four diagonals
localparam int G_A [8] = '{0, 1, 2, 3, 0, 1, 2, 3};
localparam int G_B [8] = '{4, 5, 6, 7, 5, 6, 7, 4};
localparam int G_C [8] = '{8, 9, 10, 11, 10, 11, 8, 9};
localparam int G_D [8] = '{12, 13, 14, 15, 15, 12, 13, 14};

function automatic logic [31:0] rotate_right(input logic [31:0] x, input int n);
   return (x >> n) | (x << (32 - n));
endfunction

// midstate word i at mid[32*i +: 32], message word i at msg[32*i +: 32]
function automatic logic [31:0] ref_digest7(input logic [255:0] mid,
                                            input logic [95:0]  msg,
                                            input logic [31:0]  nonce);
   logic [31:0] v [16];
   logic [31:0] m [16];
   int          a;
   int          b;
   int          c;
   int          d;
   logic [3:0]  s0;
   logic [3:0]  s1;

   for (int i = 0; i < 16; i++) begin
      m[i] = 32'h0;
   end
   m[0]  = msg[31:0];
   m[1]  = msg[63:32];
   m[2]  = msg[95:64];
   m[3]  = nonce;
   // padding of an 80-byte message: 1 bit, final 1 bit, length 640
   m[4]  = 32'h80000000;
   m[13] = 32'h00000001;
   m[15] = 32'h00000280;

   for (int i = 0; i < 8; i++) begin
      v[i]     = mid[32*i +: 32];
      v[i + 8] = blake_pkg::CONST_U[i];
   end
   // t0 = 640, t1 = 0, salt is zero
   v[12] = v[12] ^ 32'h00000280;
   v[13] = v[13] ^ 32'h00000280;

   for (int r = 0; r < 8; r++) begin
      for (int j = 0; j < 8; j++) begin
         a  = G_A[j];
         b  = G_B[j];
         c  = G_C[j];
         d  = G_D[j];
         s0 = blake_pkg::SIGMA[r][2*j];
         s1 = blake_pkg::SIGMA[r][2*j+1];
         v[a] = v[a] + v[b] + (m[s0] ^ blake_pkg::CONST_U[s1]);
         v[d] = rotate_right(v[d] ^ v[a], 16);
         v[c] = v[c] + v[d];
         v[b] = rotate_right(v[b] ^ v[c], 12);
         v[a] = v[a] + v[b] + (m[s1] ^ blake_pkg::CONST_U[s0]);
         v[d] = rotate_right(v[d] ^ v[a], 8);
         v[c] = v[c] + v[d];
         v[b] = rotate_right(v[b] ^ v[c], 7);
      end
   end

   return mid[255:224] ^ v[7] ^ v[15];
endfunction

`endif

// File: tb/tb_blake_miner.sv
/* testbench for the BLAKE-256 miner core: stimulus, scoreboard,
   assertions on the result port, reporting and watchdog */
`timescale 1ns/1ns

module tb_blake_miner;

   `include "blake_ref.svh"

   // nonce slots, header loads and pipeline drains summed over all tests
   localparam int NONCE_SLOTS     = 1 + 80 + 33 + 16;
   localparam int HEADER_LOADS    = 2;
   localparam int DRAINS          = 7;
   localparam int WATCHDOG_CYCLES = NONCE_SLOTS + HEADER_LOADS * core_pkg::HEADER_BITS
                                    + core_pkg::CORE_LATENCY * DRAINS + 200;

   typedef struct packed {
      int unsigned cyc;
      logic [31:0] nonce;
      logic [31:0] hash;
      logic        match;
   } expect_t;

   logic         clk;
   logic         rst_n_i;
   logic         shift_i;
   logic         din_i;
   logic [31:0]  nonce_i;
   logic         nonce_valid_i;
   logic [31:0]  target_i;
   logic         result_valid_o;
   logic         match_o;
   logic [31:0]  hash_o;
   logic [31:0]  nonce_o;

   expect_t      exp_q [$];
   expect_t      head;
   logic         exp_valid = 1'b0;
   logic         exp_match = 1'b0;
   logic [31:0]  exp_hash = '0;
   logic [31:0]  exp_nonce = '0;
   int unsigned  cycle_count = 0;
   int           error_count = 0;
   int           result_count = 0;
   int           test_count = 0;
   integer       seed;
   logic [255:0] cur_mid;
   logic [95:0]  cur_msg;

   blake_miner_core i_dut (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .shift_i        (shift_i),
      .din_i          (din_i),
      .nonce_i        (nonce_i),
      .nonce_valid_i  (nonce_valid_i),
      .target_i       (target_i),
      .result_valid_o (result_valid_o),
      .match_o        (match_o),
      .hash_o         (hash_o),
      .nonce_o        (nonce_o)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
   end

   // expected outputs of this cycle, settled at the falling edge
   always @(negedge clk) begin
      exp_valid = 1'b0;
      if (exp_q.size() > 0 && exp_q[0].cyc == cycle_count) begin
         head      = exp_q.pop_front();
         exp_valid = 1'b1;
         exp_match = head.match;
         exp_hash  = head.hash;
         exp_nonce = head.nonce;
         result_count++;
      end
   end

   task automatic report_mismatch(input string msg);
      error_count++;
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
   endtask

   valid_timing: assert property (@(posedge clk) disable iff (!rst_n_i)
         result_valid_o == exp_valid)
      else report_mismatch($sformatf("result_valid_o is %0b, expected %0b",
                                     $sampled(result_valid_o), exp_valid));

   match_flag: assert property (@(posedge clk) disable iff (!rst_n_i)
         match_o == (exp_valid && exp_match))
      else report_mismatch($sformatf("match_o is %0b, expected %0b",
                                     $sampled(match_o), exp_valid && exp_match));

   hash_value: assert property (@(posedge clk) disable iff (!rst_n_i)
         !exp_valid || hash_o == exp_hash)
      else report_mismatch($sformatf("hash_o is %h, expected %h",
                                     $sampled(hash_o), exp_hash));

   nonce_echo: assert property (@(posedge clk) disable iff (!rst_n_i)
         !exp_valid || nonce_o == exp_nonce)
      else report_mismatch($sformatf("nonce_o is %h, expected %h",
                                     $sampled(nonce_o), exp_nonce));

   function automatic logic [31:0] rand_word();
      return $random(seed);
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   // msb first: midstate word 7 down to 0, then message word 2 down to 0
   task automatic load_header(input logic [255:0] mid, input logic [95:0] msg);
      logic [core_pkg::HEADER_BITS-1:0] image;
      image = {mid, msg};
      for (int i = core_pkg::HEADER_BITS - 1; i >= 0; i--) begin
         shift_i = 1'b1;
         din_i   = image[i];
         next_cycle();
      end
      shift_i = 1'b0;
      din_i   = 1'b0;
      cur_mid = mid;
      cur_msg = msg;
   endtask

   task automatic load_random_header();
      logic [255:0] mid;
      logic [95:0]  msg;
      for (int i = 0; i < 8; i++) begin
         mid[32*i +: 32] = rand_word();
      end
      for (int i = 0; i < 3; i++) begin
         msg[32*i +: 32] = rand_word();
      end
      load_header(mid, msg);
   endtask

   // one clock slot of the nonce port, expected result queued when valid
   task automatic drive_slot(input logic valid, input logic [31:0] nonce);
      expect_t e;
      nonce_valid_i = valid;
      nonce_i       = nonce;
      if (valid) begin
         e.cyc   = cycle_count + core_pkg::CORE_LATENCY;
         e.nonce = nonce;
         e.hash  = ref_digest7(cur_mid, cur_msg, nonce);
         e.match = (e.hash <= target_i);
         exp_q.push_back(e);
      end
      next_cycle();
      nonce_valid_i = 1'b0;
   endtask

   task automatic drain();
      while (exp_q.size() > 0) begin
         next_cycle();
      end
      repeat (2) next_cycle();
   endtask

   task automatic finish_test(input string name, input int errs_before);
      test_count++;
      $display("test %0d (%s) done with %0d errors", test_count, name,
               error_count - errs_before);
   endtask

   initial begin
      int          errs;
      logic [31:0] r;
      logic [31:0] chosen;

      seed          = 32'h944f1cb4;
      rst_n_i       = 1'b0;
      shift_i       = 1'b0;
      din_i         = 1'b0;
      nonce_i       = '0;
      nonce_valid_i = 1'b0;
      target_i      = '1;
      cur_mid       = '0;
      cur_msg       = '0;
      repeat (2) @(posedge clk);
      #1;
      rst_n_i = 1'b1;

      errs = error_count;
      repeat (core_pkg::CORE_LATENCY + 6) next_cycle();
      finish_test("idle after reset", errs);

      errs = error_count;
      load_random_header();
      drive_slot(1'b1, rand_word());
      drain();
      finish_test("single nonce", errs);

      errs = error_count;
      repeat (40) drive_slot(1'b1, rand_word());
      for (int i = 0; i < 40; i++) begin
         r = rand_word();
         drive_slot(r[0], rand_word());
      end
      drain();
      finish_test("back-to-back and gapped bursts", errs);

      errs = error_count;
      target_i = '1;
      repeat (8) drive_slot(1'b1, rand_word());
      drain();
      target_i = '0;
      repeat (8) drive_slot(1'b1, rand_word());
      drain();
      // target at a known digest, so the compare edge is hit exactly
      chosen   = rand_word();
      target_i = ref_digest7(cur_mid, cur_msg, chosen);
      drive_slot(1'b1, chosen);
      repeat (16) drive_slot(1'b1, rand_word());
      drain();
      finish_test("target compare", errs);

      errs = error_count;
      load_random_header();
      repeat (16) drive_slot(1'b1, rand_word());
      drain();
      finish_test("header reload", errs);

      $display("%0d tests, %0d results checked, %0d errors",
               test_count, result_count, error_count);
      if (error_count == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * 8);
      $display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
      $display("Test failed");
      $finish;
   end

endmodule
